// ==== verilog/bus_pkg.sv ====
package bus_pkg;

	// ------------------------------------------------------------
	// System bus geometry
	// ------------------------------------------------------------

	// Address and data lines
	localparam int WORD_BITS = 16;

	// Processor number bits on dad_ during an interrupt serve cycle,
	// these sit at the top of the word
	localparam int IRQ_LINE_BITS = 1;

	// Only one processor on this bus
	localparam logic [IRQ_LINE_BITS-1:0] CPU_NUMBER = 1'b0;

	// ------------------------------------------------------------
	// Cycle timing
	// ------------------------------------------------------------

	localparam int TIMER_BITS = 5;

	// Strobe cycles without rok_ or ren_ before no answer
	localparam logic [TIMER_BITS-1:0] BUS_TIMEOUT = 5'd16;

	// Bus owner codes
	localparam logic [1:0] OWNER_NONE = 2'd0;
	localparam logic [1:0] OWNER_MEM  = 2'd1;
	localparam logic [1:0] OWNER_IRQ  = 2'd2;

endpackage

// ==== verilog/panel_pkg.sv ====
package panel_pkg;

	// ------------------------------------------------------------
	// Register map, word addresses
	// ------------------------------------------------------------

	localparam logic [2:0] REG_ADDR   = 3'd0;
	localparam logic [2:0] REG_DATA   = 3'd1;
	localparam logic [2:0] REG_CTRL   = 3'd2;
	localparam logic [2:0] REG_STATUS = 3'd3;
	localparam logic [2:0] REG_MASK   = 3'd4;
	localparam logic [2:0] REG_VECTOR = 3'd5;

	// Command bits in REG_CTRL
	localparam int CTRL_READ  = 0;
	localparam int CTRL_WRITE = 1;

	// ------------------------------------------------------------
	// Status word bits
	// ------------------------------------------------------------

	localparam int ST_BUSY   = 0;
	localparam int ST_NOANS  = 1;
	localparam int ST_REJECT = 2;
	localparam int ST_IRQ    = 3;

endpackage

// ==== verilog/panel_regs.sv ====
`timescale 1ns/1ns

module panel_regs import bus_pkg::*, panel_pkg::*; (
	input  logic                 __clk,
	input  logic                 reset,

	// Wishbone classic slave
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [2:0]           wb_adr,
	input  logic [WORD_BITS-1:0] wb_dat_i,
	output logic [WORD_BITS-1:0] wb_dat_o,
	output logic                 wb_ack,

	// Memory cycle command and result
	output logic                 cmd_go,
	output logic                 cmd_write,
	output logic [WORD_BITS-1:0] cmd_addr,
	output logic [WORD_BITS-1:0] cmd_data,
	input  logic                 mem_busy,
	input  logic                 mem_noans,
	input  logic                 mem_reject,
	input  logic [WORD_BITS-1:0] mem_rdata,

	// Interrupt side
	output logic                 irq_enable,
	input  logic [WORD_BITS-1:0] irq_vector,
	input  logic                 irq_pending,
	output logic                 vector_taken
);

	logic                 access;
	logic [WORD_BITS-1:0] mask;
	logic [WORD_BITS-1:0] status;

	// One wait state, ack in the second cycle of the access
	always_ff @(posedge __clk) begin
		if (reset)
			wb_ack <= 1'b0;
		else
			wb_ack <= wb_cyc & wb_stb & ~wb_ack;
	end

	// All register side effects happen in the ack cycle
	assign access = wb_cyc & wb_stb & wb_ack;

	// Address and data words
	always_ff @(posedge __clk) begin
		if (access && wb_we && wb_adr == REG_ADDR)
			cmd_addr <= wb_dat_i;
		if (access && wb_we && wb_adr == REG_DATA)
			cmd_data <= wb_dat_i;
	end

	always_ff @(posedge __clk) begin
		if (reset)
			mask <= '0;
		else if (access && wb_we && wb_adr == REG_MASK)
			mask <= wb_dat_i;
	end

	assign irq_enable = mask[0];

	// Start a bus cycle only if some command bit is set
	assign cmd_go = access & wb_we & (wb_adr == REG_CTRL)
		& (wb_dat_i[CTRL_READ] | wb_dat_i[CTRL_WRITE]);
	assign cmd_write = wb_dat_i[CTRL_WRITE];

	assign vector_taken = access & ~wb_we & (wb_adr == REG_VECTOR);

	// Error flags are only meaningful once the cycle is over
	always_comb begin
		status = '0;
		status[ST_BUSY] = mem_busy;
		status[ST_NOANS] = mem_noans & ~mem_busy;
		status[ST_REJECT] = mem_reject & ~mem_busy;
		status[ST_IRQ] = irq_pending;
	end

	// Read mux
	always_comb begin
		case (wb_adr)
			REG_ADDR:   wb_dat_o = cmd_addr;
			REG_DATA:   wb_dat_o = mem_rdata;
			REG_STATUS: wb_dat_o = status;
			REG_MASK:   wb_dat_o = mask;
			REG_VECTOR: wb_dat_o = irq_vector;
			default:    wb_dat_o = '0;
		endcase
	end

endmodule

// ==== verilog/mem_cycle.sv ====
`timescale 1ns/1ns

module mem_cycle import bus_pkg::*; (
	input  logic                 __clk,
	input  logic                 reset,

	// Command from the panel registers
	input  logic                 cmd_go,
	input  logic                 cmd_write,
	input  logic [WORD_BITS-1:0] cmd_addr,
	input  logic [WORD_BITS-1:0] cmd_data,
	output logic                 busy,
	output logic                 noans,
	output logic                 reject,
	output logic [WORD_BITS-1:0] rdata,

	// Arbiter
	output logic                 req,
	input  logic                 gnt,
	input  logic                 bus_ok,
	input  logic                 bus_en,

	// System bus, active low
	input  logic [WORD_BITS-1:0] rdt_,
	output logic [WORD_BITS-1:0] dad_,
	output logic [WORD_BITS-1:0] ddt_,
	output logic                 dr_,
	output logic                 dw_
);

	typedef enum logic [1:0] {st_idle, st_request, st_strobe, st_release} state_t;

	state_t                state;
	logic                  write_q;
	logic [WORD_BITS-1:0]  addr_q;
	logic [WORD_BITS-1:0]  data_q;
	logic [TIMER_BITS-1:0] timer;
	logic                  strobe;

	// ------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (reset) begin
			state <= st_idle;
			noans <= 1'b0;
			reject <= 1'b0;
			timer <= '0;
		end else begin
			case (state)
				st_idle: if (cmd_go) begin
					noans <= 1'b0;
					reject <= 1'b0;
					state <= st_request;
				end
				st_request: if (gnt) begin
					timer <= '0;
					state <= st_strobe;
				end
				st_strobe: begin
					timer <= timer + 1'b1;
					if (bus_ok) begin
						state <= st_release;
					end else if (bus_en) begin
						reject <= 1'b1;
						state <= st_release;
					end else if (timer == BUS_TIMEOUT - 1'b1) begin
						noans <= 1'b1;
						state <= st_release;
					end
				end
				// Wait for the slave to take its reply away
				st_release: if (!bus_ok && !bus_en)
					state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// Command latched when accepted, go is ignored while busy
	always_ff @(posedge __clk) begin
		if (state == st_idle && cmd_go) begin
			write_q <= cmd_write;
			addr_q <= cmd_addr;
			data_q <= cmd_data;
		end
	end

	always_ff @(posedge __clk) begin
		if (state == st_strobe && bus_ok && !write_q)
			rdata <= ~rdt_;
	end

	// ------------------------------------------------------------
	// Bus lines
	// ------------------------------------------------------------

	assign busy = (state != st_idle);
	assign req = busy;
	assign strobe = (state == st_strobe);

	assign dr_ = ~(strobe & ~write_q);
	assign dw_ = ~(strobe & write_q);
	assign dad_ = strobe ? ~addr_q : '1;
	assign ddt_ = (strobe && write_q) ? ~data_q : '1;

	a_strobe_granted: assert property (@(posedge __clk) disable iff (reset)
		(!dr_ || !dw_) |-> gnt)
		else $error("mem_cycle strobe low without grant");

endmodule

// ==== verilog/irq_report.sv ====
`timescale 1ns/1ns

module irq_report import bus_pkg::*; (
	input  logic                 __clk,
	input  logic                 reset,
	input  logic                 enable,
	input  logic                 rin_,
	input  logic                 vector_taken,
	output logic [WORD_BITS-1:0] vector,
	output logic                 pending,
	output logic                 irq,

	// Arbiter
	output logic                 req,
	input  logic                 gnt,
	input  logic                 bus_ok,
	input  logic                 bus_en,

	// System bus, active low
	input  logic [WORD_BITS-1:0] rdt_,
	output logic [WORD_BITS-1:0] dad_,
	output logic                 din_
);

	typedef enum logic [2:0] {
		st_idle, st_request, st_strobe, st_release, st_hold
	} state_t;

	state_t                state;
	logic                  failed;
	logic [TIMER_BITS-1:0] timer;

	always_ff @(posedge __clk) begin
		if (reset) begin
			state <= st_idle;
			failed <= 1'b0;
			pending <= 1'b0;
			timer <= '0;
		end else begin
			case (state)
				st_idle: if (enable && !rin_ && !pending) begin
					failed <= 1'b0;
					state <= st_request;
				end
				st_request: if (gnt) begin
					timer <= '0;
					state <= st_strobe;
				end
				st_strobe: begin
					timer <= timer + 1'b1;
					if (bus_ok) begin
						pending <= 1'b1;
						state <= st_release;
					end else if (bus_en || timer == BUS_TIMEOUT - 1'b1) begin
						failed <= 1'b1;
						state <= st_release;
					end
				end
				st_release: if (!bus_ok && !bus_en)
					state <= failed ? st_hold : st_idle;
				// Unserved request, let the device drop rin_ first
				st_hold: if (rin_)
					state <= st_idle;
				default: state <= st_idle;
			endcase
			if (vector_taken)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge __clk) begin
		if (state == st_strobe && bus_ok)
			vector <= ~rdt_;
	end

	assign req = (state == st_request) || (state == st_strobe) || (state == st_release);
	assign din_ = ~(state == st_strobe);
	assign irq = pending & enable;

	// Processor number in the top bits of the serve address
	always_comb begin
		dad_ = '1;
		if (state == st_strobe)
			dad_[WORD_BITS-1 -: IRQ_LINE_BITS] = ~CPU_NUMBER;
	end

	a_din_granted: assert property (@(posedge __clk) disable iff (reset)
		!din_ |-> gnt)
		else $error("irq_report din_ low without grant");

endmodule

// ==== verilog/bus_merge.sv ====
`timescale 1ns/1ns

module bus_merge import bus_pkg::*; (
	input  logic                 __clk,
	input  logic                 reset,

	input  logic                 mem_req,
	input  logic                 irq_req,
	output logic                 mem_gnt,
	output logic                 irq_gnt,

	// Unit contributions are all ones when idle
	input  logic [WORD_BITS-1:0] mem_dad_,
	input  logic [WORD_BITS-1:0] mem_ddt_,
	input  logic [WORD_BITS-1:0] irq_dad_,
	input  logic                 mem_dr_,
	input  logic                 mem_dw_,
	input  logic                 irq_din_,

	// Replies
	input  logic                 rok_,
	input  logic                 ren_,
	output logic                 mem_ok,
	output logic                 mem_en,
	output logic                 irq_ok,
	output logic                 irq_en,

	// Composed bus lines
	output logic [WORD_BITS-1:0] dad_,
	output logic [WORD_BITS-1:0] ddt_,
	output logic                 dr_,
	output logic                 dw_,
	output logic                 din_
);

	logic [1:0] owner;
	logic       owner_req;

	// Current owner still wants the bus
	assign owner_req = (owner == OWNER_MEM && mem_req) || (owner == OWNER_IRQ && irq_req);

	// ------------------------------------------------------------
	// Arbitration with the interrupt side first
	// ------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (reset)
			owner <= OWNER_NONE;
		else if (!owner_req) begin
			if (irq_req)
				owner <= OWNER_IRQ;
			else if (mem_req)
				owner <= OWNER_MEM;
			else
				owner <= OWNER_NONE;
		end
	end

	assign mem_gnt = (owner == OWNER_MEM);
	assign irq_gnt = (owner == OWNER_IRQ);

	// Open collector composition
	assign dad_ = mem_dad_ & irq_dad_;
	assign ddt_ = mem_ddt_;
	assign dr_ = mem_dr_;
	assign dw_ = mem_dw_;
	assign din_ = irq_din_;

	// Replies go to the owner only
	assign mem_ok = mem_gnt & ~rok_;
	assign mem_en = mem_gnt & ~ren_;
	assign irq_ok = irq_gnt & ~rok_;
	assign irq_en = irq_gnt & ~ren_;

	// The bus never changes hands while a strobe is low
	a_owner_stable: assert property (@(posedge __clk) disable iff (reset)
		!(dr_ && dw_ && din_) |=> $stable(owner))
		else $error("bus owner changed during a strobe");

	a_one_strobe: assert property (@(posedge __clk) disable iff (reset)
		$onehot0({~dr_, ~dw_, ~din_}))
		else $error("more than one bus strobe low");

endmodule

// ==== verilog/cpu_bus.sv ====
`timescale 1ns/1ns

module cpu_bus import bus_pkg::*; (
	input  logic                 __clk,
	input  logic                 reset,

	// Panel host, Wishbone classic
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [2:0]           wb_adr,
	input  logic [WORD_BITS-1:0] wb_dat_i,
	output logic [WORD_BITS-1:0] wb_dat_o,
	output logic                 wb_ack,

	// System bus
	output logic [WORD_BITS-1:0] dad_,
	output logic [WORD_BITS-1:0] ddt_,
	output logic                 dr_,
	output logic                 dw_,
	output logic                 din_,
	input  logic [WORD_BITS-1:0] rdt_,
	input  logic                 rok_,
	input  logic                 ren_,
	input  logic                 rin_,
	output logic                 irq
);

	logic                 cmd_go, cmd_write;
	logic [WORD_BITS-1:0] cmd_addr, cmd_data, mem_rdata;
	logic                 mem_busy, mem_noans, mem_reject;
	logic                 irq_enable, irq_pending, vector_taken;
	logic [WORD_BITS-1:0] irq_vector;
	logic                 mem_req, mem_gnt, mem_ok, mem_en, mem_dr_, mem_dw_;
	logic                 irq_req, irq_gnt, irq_ok, irq_en, irq_din_;
	logic [WORD_BITS-1:0] mem_dad_, mem_ddt_, irq_dad_;

	// ------------------------------------------------------------
	// Host registers
	// ------------------------------------------------------------

	panel_regs u_panel_regs (.*);

	// ------------------------------------------------------------
	// Bus sequencers
	// ------------------------------------------------------------

	mem_cycle u_mem_cycle (
		.__clk(__clk), .reset(reset),
		.cmd_go(cmd_go), .cmd_write(cmd_write), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.busy(mem_busy), .noans(mem_noans), .reject(mem_reject), .rdata(mem_rdata),
		.req(mem_req), .gnt(mem_gnt), .bus_ok(mem_ok), .bus_en(mem_en),
		.rdt_(rdt_), .dad_(mem_dad_), .ddt_(mem_ddt_), .dr_(mem_dr_), .dw_(mem_dw_)
	);

	irq_report u_irq_report (
		.__clk(__clk), .reset(reset),
		.enable(irq_enable), .rin_(rin_), .vector_taken(vector_taken),
		.vector(irq_vector), .pending(irq_pending), .irq(irq),
		.req(irq_req), .gnt(irq_gnt), .bus_ok(irq_ok), .bus_en(irq_en),
		.rdt_(rdt_), .dad_(irq_dad_), .din_(irq_din_)
	);

	// Arbiter and line composition
	bus_merge u_bus_merge (.*);

endmodule

// ==== testbench/tb_cpu_bus.sv ====
`timescale 1ns/1ns

module tb_cpu_bus import bus_pkg::*, panel_pkg::*; ();

	// Longest test is well under 1500 cycles
	localparam int TIMEOUT_CYCLES = 4000;
	localparam logic [15:0] VEC_BASE = 16'h0140;

	logic clk, reset;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic [2:0] wb_adr;
	logic [15:0] wb_dat_i, wb_dat_o;
	logic [15:0] dad_, ddt_, rdt_;
	logic dr_, dw_, din_, rok_, ren_, rin_, irq;

	// Bus memory and device model state
	logic [15:0] mem [64];
	logic [15:0] wlog_addr[$];
	logic [15:0] wlog_data[$];
	logic [15:0] cyc_addr;
	logic [1:0] cyc_kind;
	logic low, replied, din_bit, irq_want, irq_served;
	int hold, din_starts;

	int errors, strobe_faults, cycles;
	logic [31:0] rng_state;

	cpu_bus u_cpu_bus (
		.__clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
		.dad_(dad_), .ddt_(ddt_), .dr_(dr_), .dw_(dw_), .din_(din_),
		.rdt_(rdt_), .rok_(rok_), .ren_(ren_), .rin_(rin_), .irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Device holds rin_ low until its serve cycle is answered
	assign rin_ = ~(irq_want & ~irq_served);

	// ------------------------------------------------------------
	// Bus memory and interrupt device
	// ------------------------------------------------------------

	always @(posedge clk) begin
		#1;
		low = !dr_ || !dw_ || !din_;
		if (low && hold == 0) begin
			cyc_addr = ~dad_;
			cyc_kind = !din_ ? 2'd2 : (!dw_ ? 2'd1 : 2'd0);
			if (!dw_) begin
				wlog_addr.push_back(~dad_);
				wlog_data.push_back(~ddt_);
			end
			if (!din_) begin
				din_bit = ~dad_[WORD_BITS-1];
				din_starts = din_starts + 1;
			end
		end
		if (low)
			hold = hold + 1;
		#1;
		if (!low) begin
			if (replied && cyc_kind == 2'd2)
				irq_served = 1'b1;
			rok_ = 1'b1;
			ren_ = 1'b1;
			rdt_ = '1;
			replied = 1'b0;
			hold = 0;
		end else if (hold == 2) begin
			replied = 1'b1;
			if (cyc_kind == 2'd2) begin
				rok_ = 1'b0;
				rdt_ = ~(VEC_BASE + 16'(din_starts));
			end else if (cyc_addr < 16'd64) begin
				rok_ = 1'b0;
				if (cyc_kind == 2'd1)
					mem[cyc_addr[5:0]] = ~ddt_;
				else
					rdt_ = ~mem[cyc_addr[5:0]];
			end else if (cyc_addr >= 16'hF000) begin
				ren_ = 1'b0;
			end
		end
		if (!irq_want)
			irq_served = 1'b0;
	end

	always @(posedge clk) begin
		#1;
		if (int'(!dr_) + int'(!dw_) + int'(!din_) > 1) begin
			strobe_faults = strobe_faults + 1;
			$display("%0t: two bus strobes are low at the same time", $time);
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles without finishing", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			errors = errors + 1;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic wb_access(input logic we, input logic [2:0] adr, input logic [15:0] data,
			output logic [15:0] rdata);
		int n;
		@(posedge clk);
		#2;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_i = data;
		n = 0;
		@(posedge clk);
		#2;
		while (!wb_ack && n < 8) begin
			@(posedge clk);
			#2;
			n = n + 1;
		end
		if (!wb_ack) begin
			errors = errors + 1;
			$display("%0t: access to register %0d was never acknowledged", $time, adr);
		end
		rdata = wb_dat_o;
		// Hold the strobe through the ack edge
		@(posedge clk);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [15:0] data);
		logic [15:0] unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [15:0] data);
		wb_access(1'b0, adr, 16'h0000, data);
	endtask

	task automatic wait_idle(output logic [15:0] st);
		int n;
		n = 0;
		wb_read(REG_STATUS, st);
		while (st[ST_BUSY] && n < 60) begin
			wb_read(REG_STATUS, st);
			n = n + 1;
		end
		if (st[ST_BUSY]) begin
			errors = errors + 1;
			$display("%0t: memory cycle never finished", $time);
		end
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (!irq && n < 200) begin
			@(posedge clk);
			#2;
			n = n + 1;
		end
		if (!irq) begin
			errors = errors + 1;
			$display("%0t: interrupt output never rose", $time);
		end
	endtask

	// Write one word and check what the bus carried
	task automatic mem_write(input logic [15:0] addr, input logic [15:0] data, input bit raise_irq);
		logic [15:0] st;
		int k;
		k = wlog_addr.size();
		wb_write(REG_ADDR, addr);
		wb_write(REG_DATA, data);
		wb_write(REG_CTRL, 16'(1 << CTRL_WRITE));
		if (raise_irq)
			irq_want = 1'b1;
		wait_idle(st);
		compare("status errors", st & 16'h0006, 16'h0000);
		if (wlog_addr.size() != k + 1) begin
			errors = errors + 1;
			$display("%0t: expected one write cycle on the bus, saw %0d", $time,
				wlog_addr.size() - k);
		end else begin
			compare("dw_ address", wlog_addr[k], addr);
			compare("dw_ data", wlog_data[k], data);
		end
	endtask

	task automatic mem_read(input logic [15:0] addr, output logic [15:0] data,
			output logic [15:0] st);
		wb_write(REG_ADDR, addr);
		wb_write(REG_CTRL, 16'(1 << CTRL_READ));
		wait_idle(st);
		wb_read(REG_DATA, data);
	endtask

	// ------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------

	task automatic test_reset_regs();
		logic [15:0] v;
		compare("strobes", 16'({dr_, dw_, din_}), 16'h0007);
		compare("dad_", dad_, 16'hFFFF);
		compare("ddt_", ddt_, 16'hFFFF);
		compare("irq", 16'(irq), 16'h0000);
		wb_read(REG_STATUS, v);
		compare("status", v, 16'h0000);
		wb_write(REG_ADDR, 16'h3C96);
		wb_read(REG_ADDR, v);
		compare("REG_ADDR", v, 16'h3C96);
		wb_write(REG_MASK, 16'h0A50);
		wb_read(REG_MASK, v);
		compare("REG_MASK", v, 16'h0A50);
		wb_write(REG_MASK, 16'h0000);
	endtask

	task automatic test_write_read();
		logic [15:0] addrs [8];
		logic [15:0] words [8];
		logic [15:0] v, st;
		int base;
		rng_state = xorshift32(rng_state);
		base = int'(rng_state[5:0]);
		for (int i = 0; i < 8; i++) begin
			addrs[i] = 16'((base + i * 7) % 64);
			rng_state = xorshift32(rng_state);
			words[i] = rng_state[15:0];
			mem_write(addrs[i], words[i], 1'b0);
		end
		for (int i = 0; i < 8; i++) begin
			mem_read(addrs[i], v, st);
			compare("status errors", st & 16'h0006, 16'h0000);
			compare("REG_DATA", v, words[i]);
		end
	endtask

	task automatic test_errors();
		logic [15:0] v, st;
		mem_read(16'h0100, v, st);
		compare("status after no answer", st & 16'h0007, 16'(1 << ST_NOANS));
		compare("dad_", dad_, 16'hFFFF);
		compare("ddt_", ddt_, 16'hFFFF);
		mem_read(16'hF000, v, st);
		compare("status after reject", st & 16'h0007, 16'(1 << ST_REJECT));
		compare("dad_", dad_, 16'hFFFF);
		compare("strobes", 16'({dr_, dw_, din_}), 16'h0007);
		mem_read(16'h0005, v, st);
		compare("status after good read", st & 16'h0007, 16'h0000);
	endtask

	task automatic test_interrupt();
		logic [15:0] v;
		int n0;
		wb_write(REG_MASK, 16'h0001);
		n0 = din_starts;
		irq_want = 1'b1;
		wait_irq();
		compare("din_ cycles", 16'(din_starts - n0), 16'h0001);
		compare("dad_ cpu number", 16'(din_bit), 16'(CPU_NUMBER));
		wb_read(REG_STATUS, v);
		compare("status irq", 16'(v[ST_IRQ]), 16'h0001);
		wb_read(REG_VECTOR, v);
		compare("REG_VECTOR", v, VEC_BASE + 16'(n0 + 1));
		irq_want = 1'b0;
		compare("irq after vector read", 16'(irq), 16'h0000);

		// Masked requests must not start a serve cycle
		wb_write(REG_MASK, 16'h0000);
		n0 = din_starts;
		irq_want = 1'b1;
		repeat (100) @(posedge clk);
		#2;
		compare("din_ cycles while masked", 16'(din_starts - n0), 16'h0000);
		compare("irq while masked", 16'(irq), 16'h0000);
		irq_want = 1'b0;
	endtask

	task automatic test_shared_bus();
		logic [15:0] addrs [8];
		logic [15:0] words [8];
		logic [15:0] v, st;
		int n0;
		wb_write(REG_MASK, 16'h0001);
		n0 = din_starts;
		for (int i = 0; i < 8; i++) begin
			addrs[i] = 16'((33 + i * 5) % 64);
			rng_state = xorshift32(rng_state);
			words[i] = rng_state[15:0];
			mem_write(addrs[i], words[i], i == 3);
		end
		wait_irq();
		compare("din_ cycles", 16'(din_starts - n0), 16'h0001);
		wb_read(REG_VECTOR, v);
		compare("REG_VECTOR", v, VEC_BASE + 16'(n0 + 1));
		irq_want = 1'b0;
		for (int i = 0; i < 8; i++) begin
			mem_read(addrs[i], v, st);
			compare("REG_DATA", v, words[i]);
		end
		wb_write(REG_MASK, 16'h0000);
	endtask

	initial begin
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 3'd0;
		wb_dat_i = 16'h0000;
		rdt_ = '1;
		rok_ = 1'b1;
		ren_ = 1'b1;
		irq_want = 1'b0;
		irq_served = 1'b0;
		replied = 1'b0;
		hold = 0;
		din_starts = 0;
		din_bit = 1'b0;
		errors = 0;
		strobe_faults = 0;
		cycles = 0;
		rng_state = 32'd99;
		// Fill pattern from the whole address
		for (int i = 0; i < 64; i++)
			mem[i] = 16'(i * 16'h0405) ^ 16'h5A5A;

		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;

		test_reset_regs();
		test_write_read();
		test_errors();
		test_interrupt();
		test_shared_bus();

		$display("Checks done: %0d value errors, %0d strobe overlaps", errors, strobe_faults);
		if (errors == 0 && strobe_faults == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== flist.f ====
verilog/bus_pkg.sv
verilog/panel_pkg.sv
verilog/panel_regs.sv
verilog/mem_cycle.sv
verilog/irq_report.sv
verilog/bus_merge.sv
verilog/cpu_bus.sv
testbench/tb_cpu_bus.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_cpu_bus -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
